/* hdl/core_pkg.sv */
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_W       = 5;
    localparam int NREGS       = 32;
    localparam int QUEUE_DEPTH = 4;   // also the sender's credits
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int ROB_DEPTH   = 8;
    localparam int TAG_W       = 3;
    localparam int MUL_CYCLES  = 32;
    localparam int DIV_CYCLES  = 32;
    localparam int MUL_CNT_W   = $clog2(MUL_CYCLES);
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub, sra
    localparam logic [6:0] F7_MDIV = 7'b0000001;   // m extension

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MUL  = 3'b000;
    localparam logic [2:0] F3_DIVU = 3'b101;
    localparam logic [2:0] F3_REMU = 3'b111;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU, OP_SLL,
        OP_SRL, OP_SRA, OP_ADDI, OP_MUL, OP_DIVU, OP_REMU, OP_NOP
    } exec_op_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        exec_op_t         op;
        logic [XLEN-1:0]  opa;
        logic [XLEN-1:0]  opb;   // rs2 or immediate
    } exec_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  value;
    } exec_res_t;

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic             wr;
    } rob_alloc_t;

    typedef struct packed {
        logic             valid;
        logic [REG_W-1:0] rd;
        logic             wr;
        logic [XLEN-1:0]  value;
    } retire_t;

endpackage

/* hdl/issue_decode.sv */
`timescale 1ns/1ps

module issue_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         instr_valid,
    input  logic [31:0]                  instr,
    output logic                         credit_ret,
    output logic [core_pkg::REG_W-1:0]   rs1_addr,
    output logic [core_pkg::REG_W-1:0]   rs2_addr,
    input  logic [core_pkg::XLEN-1:0]    rs1_data,
    input  logic [core_pkg::XLEN-1:0]    rs2_data,
    input  logic                         rob_full,
    input  logic [core_pkg::TAG_W-1:0]   alloc_tag,
    output core_pkg::rob_alloc_t         alloc,
    output core_pkg::exec_req_t          alu_req,
    output core_pkg::exec_req_t          mul_req,
    output core_pkg::exec_req_t          div_req,
    input  logic                         mul_busy,
    input  logic                         div_busy,
    input  core_pkg::retire_t            retire
);

    logic [31:0]                   q_mem [core_pkg::QUEUE_DEPTH];
    logic [core_pkg::QPTR_W-1:0]   q_wr;
    logic [core_pkg::QPTR_W-1:0]   q_rd;
    logic [core_pkg::QPTR_W:0]     q_count;
    logic [31:0]                   head;
    logic [core_pkg::REG_W-1:0]    rd;
    logic [core_pkg::NREGS-1:0]    busy;   // scoreboard, one bit per register
    core_pkg::exec_op_t            op;
    logic                          wr;
    logic                          use_rs1;
    logic                          use_rs2;
    logic                          use_imm;
    logic                          to_mul;
    logic                          to_div;
    logic                          hazard;
    logic                          fire;
    core_pkg::exec_req_t           req_d;

    assign head     = q_mem[q_rd];
    assign rs1_addr = head[19:15];
    assign rs2_addr = head[24:20];
    assign rd       = head[11:7];

    always_comb begin
        op      = core_pkg::OP_NOP;
        wr      = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        if (head[6:0] == core_pkg::OPC_OP_IMM && head[14:12] == core_pkg::F3_ADD) begin
            op      = core_pkg::OP_ADDI;
            wr      = 1'b1;
            use_rs1 = 1'b1;
            use_imm = 1'b1;
        end else if (head[6:0] == core_pkg::OPC_OP) begin
            wr      = 1'b1;
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            case ({head[31:25], head[14:12]})
                {core_pkg::F7_BASE, core_pkg::F3_ADD}:  op = core_pkg::OP_ADD;
                {core_pkg::F7_ALT,  core_pkg::F3_ADD}:  op = core_pkg::OP_SUB;
                {core_pkg::F7_BASE, core_pkg::F3_AND}:  op = core_pkg::OP_AND;
                {core_pkg::F7_BASE, core_pkg::F3_OR}:   op = core_pkg::OP_OR;
                {core_pkg::F7_BASE, core_pkg::F3_XOR}:  op = core_pkg::OP_XOR;
                {core_pkg::F7_BASE, core_pkg::F3_SLT}:  op = core_pkg::OP_SLT;
                {core_pkg::F7_BASE, core_pkg::F3_SLTU}: op = core_pkg::OP_SLTU;
                {core_pkg::F7_BASE, core_pkg::F3_SLL}:  op = core_pkg::OP_SLL;
                {core_pkg::F7_BASE, core_pkg::F3_SR}:   op = core_pkg::OP_SRL;
                {core_pkg::F7_ALT,  core_pkg::F3_SR}:   op = core_pkg::OP_SRA;
                {core_pkg::F7_MDIV, core_pkg::F3_MUL}:  op = core_pkg::OP_MUL;
                {core_pkg::F7_MDIV, core_pkg::F3_DIVU}: op = core_pkg::OP_DIVU;
                {core_pkg::F7_MDIV, core_pkg::F3_REMU}: op = core_pkg::OP_REMU;
                default: begin   // unsupported, retires as nop
                    wr      = 1'b0;
                    use_rs1 = 1'b0;
                    use_rs2 = 1'b0;
                end
            endcase
        end
    end

    assign to_mul = (op == core_pkg::OP_MUL);
    assign to_div = (op == core_pkg::OP_DIVU) || (op == core_pkg::OP_REMU);
    assign hazard = (use_rs1 && busy[rs1_addr]) || (use_rs2 && busy[rs2_addr])
                    || (wr && busy[rd]);
    assign fire   = (q_count != '0) && !hazard && !rob_full
                    && !(to_mul && mul_busy) && !(to_div && div_busy);

    assign alloc = '{valid: fire, rd: rd, wr: wr};
    assign req_d = '{valid: 1'b1, tag: alloc_tag, op: op, opa: rs1_data,
                     opb: use_imm ? {{20{head[31]}}, head[31:20]} : rs2_data};

    always_ff @(posedge clk) begin
        if (instr_valid)
            q_mem[q_wr] <= instr;   // credits keep the queue from overflowing
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr       <= '0;
            q_rd       <= '0;
            q_count    <= '0;
            busy       <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (instr_valid)
                q_wr <= q_wr + 1'b1;
            if (fire)
                q_rd <= q_rd + 1'b1;
            q_count    <= q_count + (core_pkg::QPTR_W + 1)'(instr_valid)
                          - (core_pkg::QPTR_W + 1)'(fire);
            credit_ret <= fire;
            if (retire.valid && retire.wr)
                busy[retire.rd] <= 1'b0;
            if (fire && wr && rd != '0)
                busy[rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        alu_req <= req_d;
        mul_req <= req_d;
        div_req <= req_d;
        if (rst) begin
            alu_req.valid <= 1'b0;
            mul_req.valid <= 1'b0;
            div_req.valid <= 1'b0;
        end else begin
            alu_req.valid <= fire && !to_mul && !to_div;   // nop included
            mul_req.valid <= fire && to_mul;
            div_req.valid <= fire && to_div;
        end
    end

endmodule

/* hdl/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::exec_req_t req,
    output core_pkg::exec_res_t res
);

    logic [core_pkg::XLEN-1:0] result;
    logic [4:0]                shamt;

    assign shamt = req.opb[4:0];

    always_comb begin
        case (req.op)
            core_pkg::OP_ADD,
            core_pkg::OP_ADDI: result = req.opa + req.opb;
            core_pkg::OP_SUB:  result = req.opa - req.opb;
            core_pkg::OP_AND:  result = req.opa & req.opb;
            core_pkg::OP_OR:   result = req.opa | req.opb;
            core_pkg::OP_XOR:  result = req.opa ^ req.opb;
            core_pkg::OP_SLT:  result = {{(core_pkg::XLEN-1){1'b0}},
                                         $signed(req.opa) < $signed(req.opb)};
            core_pkg::OP_SLTU: result = {{(core_pkg::XLEN-1){1'b0}}, req.opa < req.opb};
            core_pkg::OP_SLL:  result = req.opa << shamt;
            core_pkg::OP_SRL:  result = req.opa >> shamt;
            core_pkg::OP_SRA:  result = $unsigned($signed(req.opa) >>> shamt);
            default:           result = '0;   // nop
        endcase
    end

    always_ff @(posedge clk) begin
        res.tag   <= req.tag;
        res.value <= result;
        if (rst)
            res.valid <= 1'b0;
        else
            res.valid <= req.valid;
    end

endmodule

/* hdl/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::exec_req_t req,
    output logic                busy,
    output core_pkg::exec_res_t res
);

    logic                             running;
    logic                             done_q;
    logic [core_pkg::MUL_CNT_W-1:0]   cnt;
    logic                             last;
    logic [core_pkg::XLEN-1:0]        acc;
    logic [core_pkg::XLEN-1:0]        mcand;
    logic [core_pkg::XLEN-1:0]        mplier;
    logic [core_pkg::XLEN-1:0]        acc_next;
    logic [core_pkg::TAG_W-1:0]       tag_q;

    assign last     = (cnt == (core_pkg::MUL_CNT_W)'(core_pkg::MUL_CYCLES - 1));
    assign acc_next = mplier[0] ? acc + mcand : acc;
    assign busy     = running | req.valid;
    assign res      = '{valid: done_q, tag: tag_q, value: acc};   // acc holds the product

    always_ff @(posedge clk) begin
        if (req.valid) begin
            acc    <= '0;
            mcand  <= req.opa;
            mplier <= req.opb;
            tag_q  <= req.tag;
        end else if (running) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end

        if (rst) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            cnt     <= '0;
        end else begin
            done_q <= running && last;
            if (req.valid) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (last)
                    running <= 1'b0;
            end
        end
    end

endmodule

/* hdl/div_unit.sv */
`timescale 1ns/1ps

module div_unit (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::exec_req_t req,
    output logic                busy,
    output core_pkg::exec_res_t res
);

    logic                             running;
    logic                             done_q;
    logic [core_pkg::DIV_CNT_W-1:0]   cnt;
    logic                             last;
    logic [core_pkg::XLEN-1:0]        rem;
    logic [core_pkg::XLEN-1:0]        quo;    // dividend shifts out, quotient shifts in
    logic [core_pkg::XLEN-1:0]        dvsr;
    logic [core_pkg::XLEN:0]          r_shift;
    logic [core_pkg::XLEN:0]          diff;
    logic                             op_rem;
    logic [core_pkg::TAG_W-1:0]       tag_q;

    assign last    = (cnt == (core_pkg::DIV_CNT_W)'(core_pkg::DIV_CYCLES - 1));
    assign r_shift = {rem, quo[core_pkg::XLEN-1]};
    assign diff    = r_shift - {1'b0, dvsr};
    assign busy    = running | req.valid;
    assign res     = '{valid: done_q, tag: tag_q, value: op_rem ? rem : quo};

    // zero divisor never restores, which leaves all ones and the dividend
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rem    <= '0;
            quo    <= req.opa;
            dvsr   <= req.opb;
            op_rem <= (req.op == core_pkg::OP_REMU);
            tag_q  <= req.tag;
        end else if (running) begin
            if (!diff[core_pkg::XLEN]) begin
                rem <= diff[core_pkg::XLEN-1:0];
                quo <= {quo[core_pkg::XLEN-2:0], 1'b1};
            end else begin
                rem <= r_shift[core_pkg::XLEN-1:0];   // restore
                quo <= {quo[core_pkg::XLEN-2:0], 1'b0};
            end
        end

        if (rst) begin
            running <= 1'b0;
            done_q  <= 1'b0;
            cnt     <= '0;
        end else begin
            done_q <= running && last;
            if (req.valid) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (last)
                    running <= 1'b0;
            end
        end
    end

endmodule

/* hdl/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  core_pkg::rob_alloc_t       alloc,
    output logic [core_pkg::TAG_W-1:0] alloc_tag,
    output logic                       full,
    input  core_pkg::exec_res_t        alu_res,
    input  core_pkg::exec_res_t        mul_res,
    input  core_pkg::exec_res_t        div_res,
    output core_pkg::retire_t          retire
);

    logic [core_pkg::TAG_W-1:0]    head;
    logic [core_pkg::TAG_W-1:0]    tail;
    logic [core_pkg::TAG_W:0]      count;
    logic [core_pkg::ROB_DEPTH-1:0] done;
    logic [core_pkg::ROB_DEPTH-1:0] wr_q;
    logic [core_pkg::REG_W-1:0]    rd_q  [core_pkg::ROB_DEPTH];
    logic [core_pkg::XLEN-1:0]     val_q [core_pkg::ROB_DEPTH];
    logic                          head_done;
    logic [core_pkg::XLEN-1:0]     head_val;
    logic                          do_retire;

    assign alloc_tag = tail;
    assign full      = (count == (core_pkg::TAG_W + 1)'(core_pkg::ROB_DEPTH));

    // head completing this cycle retires at the next edge
    always_comb begin
        head_done = done[head];
        head_val  = val_q[head];
        if (alu_res.valid && alu_res.tag == head) begin
            head_done = 1'b1;
            head_val  = alu_res.value;
        end
        if (mul_res.valid && mul_res.tag == head) begin
            head_done = 1'b1;
            head_val  = mul_res.value;
        end
        if (div_res.valid && div_res.tag == head) begin
            head_done = 1'b1;
            head_val  = div_res.value;
        end
    end

    assign do_retire = (count != '0) && head_done;

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            rd_q[tail] <= alloc.rd;
            wr_q[tail] <= alloc.wr;
        end
        if (alu_res.valid)
            val_q[alu_res.tag] <= alu_res.value;
        if (mul_res.valid)
            val_q[mul_res.tag] <= mul_res.value;
        if (div_res.valid)
            val_q[div_res.tag] <= div_res.value;
    end

    always_ff @(posedge clk) begin
        retire.rd    <= rd_q[head];
        retire.wr    <= wr_q[head];
        retire.value <= head_val;
        if (rst) begin
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            done         <= '0;
            retire.valid <= 1'b0;
        end else begin
            if (alu_res.valid)
                done[alu_res.tag] <= 1'b1;
            if (mul_res.valid)
                done[mul_res.tag] <= 1'b1;
            if (div_res.valid)
                done[div_res.tag] <= 1'b1;
            if (do_retire) begin
                done[head] <= 1'b0;   // slot free again
                head       <= head + 1'b1;
            end
            if (alloc.valid)
                tail <= tail + 1'b1;
            count        <= count + (core_pkg::TAG_W + 1)'(alloc.valid)
                            - (core_pkg::TAG_W + 1)'(do_retire);
            retire.valid <= do_retire;
        end
    end

endmodule

/* hdl/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [core_pkg::REG_W-1:0] rs1_addr,
    input  logic [core_pkg::REG_W-1:0] rs2_addr,
    output logic [core_pkg::XLEN-1:0]  rs1_data,
    output logic [core_pkg::XLEN-1:0]  rs2_data,
    input  core_pkg::retire_t          retire
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NREGS];

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < core_pkg::NREGS; i++)
                regs[i] <= '0;
        end else if (retire.valid && retire.wr && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;   // x0 never written
        end
    end

endmodule

/* hdl/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    output logic              credit_ret,
    output core_pkg::retire_t retire
);

    logic [core_pkg::REG_W-1:0] rs1_addr;
    logic [core_pkg::REG_W-1:0] rs2_addr;
    logic [core_pkg::XLEN-1:0]  rs1_data;
    logic [core_pkg::XLEN-1:0]  rs2_data;
    logic                       rob_full;
    logic [core_pkg::TAG_W-1:0] alloc_tag;
    core_pkg::rob_alloc_t       alloc;
    core_pkg::exec_req_t        alu_req;
    core_pkg::exec_req_t        mul_req;
    core_pkg::exec_req_t        div_req;
    logic                       mul_busy;
    logic                       div_busy;
    core_pkg::exec_res_t        alu_res;
    core_pkg::exec_res_t        mul_res;
    core_pkg::exec_res_t        div_res;

    issue_decode u_issue_decode (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .credit_ret(credit_ret),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rob_full(rob_full), .alloc_tag(alloc_tag), .alloc(alloc),
        .alu_req(alu_req), .mul_req(mul_req), .div_req(div_req),
        .mul_busy(mul_busy), .div_busy(div_busy),
        .retire(retire)
    );

    alu_unit u_alu_unit (.clk(clk), .rst(rst), .req(alu_req), .res(alu_res));

    mul_unit u_mul_unit (.clk(clk), .rst(rst), .req(mul_req), .busy(mul_busy), .res(mul_res));

    div_unit u_div_unit (.clk(clk), .rst(rst), .req(div_req), .busy(div_busy), .res(div_res));

    reorder_buffer u_reorder_buffer (
        .clk(clk), .rst(rst),
        .alloc(alloc), .alloc_tag(alloc_tag), .full(rob_full),
        .alu_res(alu_res), .mul_res(mul_res), .div_res(div_res),
        .retire(retire)
    );

    arch_regfile u_arch_regfile (
        .clk(clk), .rst(rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .retire(retire)
    );

endmodule

/* bench/core_asserts.sv */
`timescale 1ns/1ps

module core_asserts (
    input logic              clk,
    input logic              rst,
    input logic              instr_valid,
    input logic              credit_ret,
    input core_pkg::retire_t retire
);

    logic [3:0] outstanding;   // sent but not yet returned

    always_ff @(posedge clk) begin
        if (rst)
            outstanding <= '0;
        else
            outstanding <= outstanding + 4'(instr_valid) - 4'(credit_ret);
    end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !retire.valid && !credit_ret)
        else $error("retire or credit_ret active in the cycle after reset");

    // nop results are zero
    no_write_value: assert property (@(posedge clk) disable iff (rst)
        retire.valid && !retire.wr |-> retire.value == '0)
        else $error("retire without write carries a nonzero value");

    credit_bound: assert property (@(posedge clk) disable iff (rst)
        outstanding <= 4'(core_pkg::QUEUE_DEPTH))
        else $error("more instructions outstanding than queue entries");

    credit_match: assert property (@(posedge clk) disable iff (rst)
        credit_ret |-> outstanding != '0)
        else $error("credit returned with no instruction outstanding");

endmodule

bind ooo_core core_asserts u_core_asserts (
    .clk(clk),
    .rst(rst),
    .instr_valid(instr_valid),
    .credit_ret(credit_ret),
    .retire(retire)
);

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

    logic              clk;
    logic              rst;
    logic              instr_valid;
    logic [31:0]       instr;
    logic              credit_ret;
    core_pkg::retire_t retire;

    logic [31:0]       ref_regs [32];
    core_pkg::retire_t expected [$];
    logic [31:0]       rng_state = 32'd48;
    int                sent = 0;
    int                returned = 0;
    int                errors = 0;
    int                timeouts = 0;
    logic              timed_out = 1'b0;

    ooo_core UUT (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr),
        .credit_ret(credit_ret), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_word(input int sel, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [11:0] imm);
        case (sel)
            0:       return encode_r(7'h00, 3'b000, rd, rs1, rs2);
            1:       return encode_r(7'h20, 3'b000, rd, rs1, rs2);
            2:       return encode_r(7'h00, 3'b111, rd, rs1, rs2);
            3:       return encode_r(7'h00, 3'b110, rd, rs1, rs2);
            4:       return encode_r(7'h00, 3'b100, rd, rs1, rs2);
            5:       return encode_r(7'h00, 3'b010, rd, rs1, rs2);
            6:       return encode_r(7'h00, 3'b011, rd, rs1, rs2);
            7:       return encode_r(7'h00, 3'b001, rd, rs1, rs2);
            8:       return encode_r(7'h00, 3'b101, rd, rs1, rs2);
            9:       return encode_r(7'h20, 3'b101, rd, rs1, rs2);
            default: return encode_i(3'b000, rd, rs1, imm);
        endcase
    endfunction

    // sequential execution of one word against the reference registers
    function automatic core_pkg::retire_t predict(input logic [31:0] w);
        core_pkg::retire_t e;
        logic [31:0]       a;
        logic [31:0]       b;
        a       = ref_regs[w[19:15]];
        b       = ref_regs[w[24:20]];
        e.valid = 1'b1;
        e.rd    = w[11:7];
        e.wr    = 1'b1;
        e.value = '0;
        if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
            e.value = a + {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == 7'b0110011) begin
            case ({w[31:25], w[14:12]})
                10'b0000000_000: e.value = a + b;
                10'b0100000_000: e.value = a - b;
                10'b0000000_111: e.value = a & b;
                10'b0000000_110: e.value = a | b;
                10'b0000000_100: e.value = a ^ b;
                10'b0000000_010: e.value = {31'b0, $signed(a) < $signed(b)};
                10'b0000000_011: e.value = {31'b0, a < b};
                10'b0000000_001: e.value = a << b[4:0];
                10'b0000000_101: e.value = a >> b[4:0];
                10'b0100000_101: e.value = $signed(a) >>> b[4:0];
                10'b0000001_000: e.value = a * b;
                10'b0000001_101: e.value = (b == 0) ? 32'hffff_ffff : a / b;
                10'b0000001_111: e.value = (b == 0) ? a : a % b;
                default:         e.wr = 1'b0;
            endcase
        end else begin
            e.wr = 1'b0;
        end
        return e;
    endfunction

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        timeouts++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send(input logic [31:0] word);
        int t;
        t = 0;
        while (sent - returned >= core_pkg::QUEUE_DEPTH && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > 200)
                report_timeout("no credit came back to send the next instruction");
        end
        if (!timed_out) begin
            instr_valid = 1'b1;
            instr       = word;
            sent++;
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic issue(input logic [31:0] word);
        core_pkg::retire_t e;
        if (!timed_out) begin
            e = predict(word);
            if (e.wr && e.rd != 5'd0)
                ref_regs[e.rd] = e.value;
            expected.push_back(e);
            send(word);
        end
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (expected.size() != 0 && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > 1000)
                report_timeout("instructions never retired");
        end
    endtask

    // x29 scratch, x30 and x31 hold shift amounts 10 and 11
    task automatic load_value(input logic [4:0] rd, input logic [31:0] v);
        issue(encode_i(3'b000, rd, 5'd0, {1'b0, v[31:21]}));
        issue(encode_r(7'h00, 3'b001, rd, rd, 5'd31));
        issue(encode_i(3'b000, 5'd29, 5'd0, {1'b0, v[20:10]}));
        issue(encode_r(7'h00, 3'b110, rd, rd, 5'd29));
        issue(encode_r(7'h00, 3'b001, rd, rd, 5'd30));
        issue(encode_i(3'b000, 5'd29, 5'd0, {2'b0, v[9:0]}));
        issue(encode_r(7'h00, 3'b110, rd, rd, 5'd29));
    endtask

    task automatic check_credit_flow();
        int t;
        issue(encode_i(3'b000, 5'd2, 5'd0, 12'd1000));
        issue(encode_i(3'b000, 5'd3, 5'd0, 12'd7));
        drain();
        issue(encode_r(7'h01, 3'b101, 5'd1, 5'd2, 5'd3));   // long divu at the head
        issue(encode_r(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
        issue(encode_r(7'h20, 3'b000, 5'd5, 5'd4, 5'd1));
        issue(encode_r(7'h00, 3'b100, 5'd6, 5'd1, 5'd5));
        t = 0;
        while (returned != sent && !timed_out) begin
            @(negedge clk);
            t++;
            if (t > 200)
                report_timeout("credits were not all returned");
        end
        drain();
    endtask

    task automatic check_alu_ops();
        logic [31:0] r;
        for (int i = 1; i < 16; i++) begin
            r = next_random();
            issue(encode_i(3'b000, 5'(i), 5'd0, r[11:0]));
        end
        for (int n = 0; n < 24; n++) begin
            r = next_random();
            issue(alu_word(int'(r[31:28]) % 11, 5'(1 + int'(r[3:0]) % 15),
                           {1'b0, r[7:4]}, {1'b0, r[11:8]}, r[27:16]));
        end
        drain();
    endtask

    task automatic check_mul_div();
        logic [31:0] a;
        logic [31:0] b;
        issue(encode_i(3'b000, 5'd30, 5'd0, 12'd10));
        issue(encode_i(3'b000, 5'd31, 5'd0, 12'd11));
        for (int n = 0; n < 4; n++) begin
            a = next_random();
            b = next_random();
            if (n % 2 == 1)
                b = b >> 20;   // small divisor, wide quotient
            load_value(5'd10, a);
            load_value(5'd11, b);
            issue(encode_r(7'h01, 3'b000, 5'd12, 5'd10, 5'd11));
            issue(encode_r(7'h01, 3'b101, 5'd13, 5'd10, 5'd11));
            issue(encode_r(7'h01, 3'b111, 5'd14, 5'd10, 5'd11));
        end
        issue(encode_r(7'h01, 3'b101, 5'd15, 5'd10, 5'd0));
        issue(encode_r(7'h01, 3'b111, 5'd16, 5'd10, 5'd0));
        drain();
    endtask

    task automatic check_hazards();
        issue(encode_r(7'h01, 3'b101, 5'd5, 5'd10, 5'd11));
        issue(encode_i(3'b000, 5'd7, 5'd2, 12'd5));            // independent of the divide
        issue(encode_r(7'h00, 3'b000, 5'd6, 5'd5, 5'd1));      // raw on x5
        issue(encode_r(7'h01, 3'b000, 5'd9, 5'd10, 5'd11));
        issue(encode_i(3'b000, 5'd9, 5'd1, 12'd3));            // waw on x9
        issue(encode_r(7'h00, 3'b100, 5'd8, 5'd9, 5'd6));
        drain();
    endtask

    task automatic check_x0_illegal();
        issue(encode_i(3'b000, 5'd0, 5'd3, 12'd99));
        issue(encode_r(7'h00, 3'b000, 5'd17, 5'd0, 5'd3));
        issue(32'h1234_50b7);                                  // lui x1
        issue(encode_r(7'h01, 3'b100, 5'd18, 5'd10, 5'd11));   // signed div
        issue(encode_i(3'b010, 5'd19, 5'd3, 12'd5));           // slti
        issue(encode_r(7'h00, 3'b000, 5'd20, 5'd1, 5'd0));
        issue(encode_r(7'h00, 3'b000, 5'd21, 5'd18, 5'd19));
        drain();
    endtask

    always @(posedge clk) begin : monitor
        core_pkg::retire_t want;
        if (!rst) begin
            if (credit_ret)
                returned++;
            if (retire.valid) begin
                assert (expected.size() != 0) else begin
                    errors++;
                    $display("retire at %0t with no instruction outstanding", $time);
                end
                if (expected.size() != 0) begin
                    want = expected.pop_front();
                    assert (retire == want) else begin
                        errors++;
                        $display("Mismatch at %0t: rd/wr/value %0d/%0b/%h, expected %0d/%0b/%h",
                                 $time, retire.rd, retire.wr, retire.value,
                                 want.rd, want.wr, want.value);
                    end
                end
            end
        end
    end

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_credit_flow();
        check_alu_ops();
        check_mul_div();
        check_hazards();
        check_x0_illegal();
        drain();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* src.f */
hdl/core_pkg.sv
hdl/issue_decode.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/reorder_buffer.sv
hdl/arch_regfile.sv
hdl/ooo_core.sv
bench/core_asserts.sv
bench/core_tb.sv

/* Makefile */
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

obj_dir/Vcore_tb: src.f $(SRCS)
	verilator --binary --assert --top-module core_tb -f src.f -o Vcore_tb

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
